// ==== baton_tracker.f ====
hdl/baton_pkg.sv
hdl/pixel_reconstruct.sv
hdl/cr_threshold.sv
hdl/center_of_mass.sv
hdl/beat_detector.sv
hdl/telemetry_tx.sv
hdl/baton_tracker.sv
test/tb_baton_tracker.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line
verilator --binary --assert -f baton_tracker.f --top-module tb_baton_tracker \
   && ./obj_dir/Vtb_baton_tracker | grep "Testbench passed" \
   || { echo "simulation did not pass"; exit 1; }

// ==== test/tb_baton_tracker.sv ====
`timescale 1ns/1ns

module tb_baton_tracker import baton_pkg::*; ();

   // starts low before any process runs, so time zero has no clock edge
   logic                clk_camera = 1'b0;
   logic                sys_rst_camera;
   logic [7:0]          camera_d_i;
   logic                cam_pclk_i;
   logic                cam_hsync_i;
   logic                cam_vsync_i;
   logic [HCOUNT_W-1:0] x_com_o;
   logic [VCOUNT_W-1:0] y_com_o;
   logic                com_valid_o;
   logic                beat_o;
   logic                uart_txd_o;

   // stimulus side, written by the main process only
   logic [31:0]         rng_state;
   logic                checking;
   int                  com_expected;
   logic [HCOUNT_W-1:0] exp_x;
   logic [VCOUNT_W-1:0] exp_y;
   // monitor side model of center, direction and beat
   int                  com_count = 0;
   logic [HCOUNT_W-1:0] held_x = '0;
   logic [VCOUNT_W-1:0] held_y = '0;
   logic [VCOUNT_W-1:0] prev_y = '0;
   logic                dir_down = 1'b0;
   logic                beat_due = 1'b0;
   // beats since the last flag latch, through the last negedge and the one before
   logic                seen = 1'b0;
   logic                seen_old = 1'b0;
   logic                beat_last = 1'b0;
   logic [VCOUNT_W-1:0] y_last = '0;
   logic                uart_prev = 1'b1;
   // uart receiver, rx_cnt counts negedges since the start bit was seen
   int                  rx_cnt = 0;
   int                  rx_count = 0;
   logic [7:0]          rx_byte = '0;
   logic                next_is_flag = 1'b0;
   logic [VCOUNT_W-1:0] snap_y = '0;
   logic                snap_flag = 1'b0;

   baton_tracker DUT (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .camera_d_i     (camera_d_i),
      .cam_pclk_i     (cam_pclk_i),
      .cam_hsync_i    (cam_hsync_i),
      .cam_vsync_i    (cam_vsync_i),
      .x_com_o        (x_com_o),
      .y_com_o        (y_com_o),
      .com_valid_o    (com_valid_o),
      .beat_o         (beat_o),
      .uart_txd_o     (uart_txd_o)
   );

   always #20 clk_camera = ~clk_camera;

   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("Testbench failed");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic report_mismatch(input string msg);
      stop_with_error($sformatf("Mismatch at %0t ns: %s", $time, msg));
   endtask

   // numerical recipes lcg constants
   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   // pink window on cr, fields widened by zero fill
   function automatic logic in_window(input logic [15:0] pix);
      int r8;
      int g8;
      int b8;
      int cr;
      r8 = int'({pix[15:11], 3'b000});
      g8 = int'({pix[10:5], 2'b00});
      b8 = int'({pix[4:0], 3'b000});
      // >>> on a signed int floors the quotient
      cr = 128 + ((112 * r8 - 94 * g8 - 18 * b8) >>> 8);
      return (cr >= CR_LOW) && (cr <= CR_HIGH);
   endfunction

   task automatic pick_pixel(input logic want, output logic [15:0] pix);
      logic [31:0] r;
      for (int tries = 0; tries < 16; tries++) begin
         r = next_rand();
         pix = r[31:16];
         if (want) begin
            // strong red and weak green land inside the window
            pix[15:14] = 2'b11;
            pix[10:9] = 2'b00;
         end else begin
            pix[15:14] = 2'b00;
         end
         if (in_window(pix) == want) begin
            return;
         end
      end
      stop_with_error("could not draw a pixel of the wanted color class");
   endtask

   // one pclk period, low for 2 clocks then high for 2
   task automatic pclk_cycle(input logic [7:0] data, input logic hsync);
      @(negedge clk_camera);
      cam_pclk_i = 1'b0;
      cam_hsync_i = hsync;
      camera_d_i = data;
      repeat (2) @(negedge clk_camera);
      cam_pclk_i = 1'b1;
      @(negedge clk_camera);
   endtask

   task automatic send_frame(input int x0, input int y0, input int side, input logic visible);
      logic [15:0] pix;
      logic        want;
      int          sum_x;
      int          sum_y;
      int          cnt;
      sum_x = 0;
      sum_y = 0;
      cnt = 0;
      cam_vsync_i = 1'b1;
      repeat (4) pclk_cycle(8'h00, 1'b0);
      cam_vsync_i = 1'b0;
      repeat (2) pclk_cycle(8'h00, 1'b0);
      for (int v = 0; v < FRAME_H; v++) begin
         for (int h = 0; h < FRAME_W; h++) begin
            want = visible && (h >= x0) && (h < x0 + side) && (v >= y0) && (v < y0 + side);
            pick_pixel(want, pix);
            // only pixels passing the cr rule enter the sums
            if (in_window(pix)) begin
               sum_x += h;
               sum_y += v;
               cnt++;
            end
            pclk_cycle(pix[15:8], 1'b1);
            pclk_cycle(pix[7:0], 1'b1);
         end
         if ((v == FRAME_H - 1) && (cnt != 0)) begin
            exp_x = HCOUNT_W'(sum_x / cnt);
            exp_y = VCOUNT_W'(sum_y / cnt);
            com_expected++;
         end
         // hsync low gap between lines
         repeat (8) pclk_cycle(8'h00, 1'b0);
      end
   endtask

   always @(negedge clk_camera) begin
      logic fell;
      int   k;
      if (checking) begin
         assert (beat_o == beat_due) else
            report_mismatch($sformatf("beat_o=%0b expected %0b", beat_o, beat_due));
         beat_due = 1'b0;
         if (com_valid_o) begin
            assert (com_count < com_expected) else
               report_mismatch("com_valid_o pulsed with no frame result due");
            assert ((x_com_o == exp_x) && (y_com_o == exp_y)) else
               report_mismatch($sformatf("center (%0d,%0d) expected (%0d,%0d)",
                                         x_com_o, y_com_o, exp_x, exp_y));
            com_count++;
            held_x = exp_x;
            held_y = exp_y;
            // larger y is further down the picture
            beat_due = dir_down && (exp_y < prev_y);
            if (exp_y > prev_y) begin
               dir_down = 1'b1;
            end else if (exp_y < prev_y) begin
               dir_down = 1'b0;
            end
            prev_y = exp_y;
         end else begin
            assert ((x_com_o == held_x) && (y_com_o == held_y)) else
               report_mismatch($sformatf("center moved to (%0d,%0d) without com_valid_o",
                                         x_com_o, y_com_o));
         end
         // falling edge on an idle line is a start bit
         fell = (rx_cnt == 0) && uart_prev && !uart_txd_o;
         if (fell) begin
            snap_y = y_last;
            snap_flag = seen_old;
            rx_cnt = 1;
         end else if (rx_cnt != 0) begin
            // sample near the middle of each bit
            if ((rx_cnt % 8) == 3) begin
               k = rx_cnt / 8;
               if (k == 0) begin
                  assert (!uart_txd_o) else
                     stop_with_error("UART start bit did not stay low");
               end else if (k <= 8) begin
                  rx_byte = {uart_txd_o, rx_byte[7:1]};
               end else begin
                  assert (uart_txd_o) else
                     report_mismatch("UART stop bit is 0");
                  if (next_is_flag) begin
                     assert (rx_byte == {snap_flag, 7'b0}) else
                        report_mismatch($sformatf("flag byte %02h expected %02h",
                                                  rx_byte, {snap_flag, 7'b0}));
                  end else begin
                     assert (rx_byte == snap_y) else
                        report_mismatch($sformatf("y byte %02h expected %02h",
                                                  rx_byte, snap_y));
                  end
                  next_is_flag = !next_is_flag;
                  rx_count++;
                  rx_cnt = 0;
               end
            end
            if (rx_cnt != 0) begin
               rx_cnt++;
            end
         end
         // flag latch restarts the beat history
         if (fell && next_is_flag) begin
            seen_old = beat_last;
            seen = beat_last | beat_o;
         end else begin
            seen_old = seen;
            seen = seen | beat_o;
         end
         beat_last = beat_o;
         y_last = y_com_o;
         uart_prev = uart_txd_o;
      end
   end

   initial begin
      int walk_y;
      int side;
      int sq_x;
      int step;
      int wait_cnt;
      camera_d_i = 8'h00;
      cam_pclk_i = 1'b0;
      cam_hsync_i = 1'b0;
      cam_vsync_i = 1'b0;
      sys_rst_camera = 1'b1;
      checking = 1'b0;
      com_expected = 0;
      exp_x = '0;
      exp_y = '0;
      rng_state = 32'h3e71_7f54;
      walk_y = 20;
      repeat (5) @(negedge clk_camera);
      sys_rst_camera = 1'b0;
      checking = 1'b1;
      // quiet camera, line stays idle up to the first report slot
      for (int i = 0; i < REPORT_Y_AT - 5; i++) begin
         @(negedge clk_camera);
         assert (uart_txd_o == 1'b1) else
            report_mismatch("uart_txd_o left idle before the first report");
      end
      for (int f = 0; f < 10; f++) begin
         side = 12 + int'(next_rand() % 32'd19);
         sq_x = int'(next_rand() % 32'(FRAME_W - side + 1));
         step = 4 + int'(next_rand() % 32'd12);
         // two frames down, two frames up
         if (((f / 2) % 2) == 0) begin
            walk_y += step;
         end else begin
            walk_y -= step;
         end
         if (walk_y < 0) begin
            walk_y = 0;
         end
         if (walk_y > FRAME_H - 31) begin
            walk_y = FRAME_H - 31;
         end
         // frame 6 has the square off the picture
         send_frame(sq_x, walk_y, side, f != 6);
         wait_cnt = 0;
         while (com_count != com_expected) begin
            @(negedge clk_camera);
            wait_cnt++;
            if (wait_cnt > 400) begin
               stop_with_error("center-of-mass result did not arrive after the frame end");
            end
         end
         repeat (16) pclk_cycle(8'h00, 1'b0);
      end
      if (rx_count > 20) begin
         $display("Testbench passed");
         $finish;
      end else begin
         stop_with_error($sformatf("run ended with only %0d UART bytes received", rx_count));
      end
   end

endmodule

// ==== hdl/baton_tracker.sv ====
`timescale 1ns/1ns
`default_nettype none

module baton_tracker import baton_pkg::*; (
   input  logic                clk_camera,
   input  logic                sys_rst_camera,
   input  logic [7:0]          camera_d_i,
   input  logic                cam_pclk_i,
   input  logic                cam_hsync_i,
   input  logic                cam_vsync_i,
   output logic [HCOUNT_W-1:0] x_com_o,
   output logic [VCOUNT_W-1:0] y_com_o,
   output logic                com_valid_o,
   output logic                beat_o,
   output logic                uart_txd_o
);

   // assembled pixels
   logic                pixel_valid;
   logic [15:0]         pixel_data;
   logic [HCOUNT_W-1:0] pixel_hcount;
   logic [VCOUNT_W-1:0] pixel_vcount;
   // pink mask, two cycles behind the pixels
   logic                mask_valid;
   logic                mask;
   logic [HCOUNT_W-1:0] mask_hcount;
   logic [VCOUNT_W-1:0] mask_vcount;

   pixel_reconstruct u_pixel_reconstruct (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .camera_d_i     (camera_d_i),
      .cam_pclk_i     (cam_pclk_i),
      .cam_hsync_i    (cam_hsync_i),
      .cam_vsync_i    (cam_vsync_i),
      .pixel_valid_o  (pixel_valid),
      .pixel_data_o   (pixel_data),
      .hcount_o       (pixel_hcount),
      .vcount_o       (pixel_vcount)
   );

   cr_threshold u_cr_threshold (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .pixel_valid_i  (pixel_valid),
      .pixel_data_i   (pixel_data),
      .hcount_i       (pixel_hcount),
      .vcount_i       (pixel_vcount),
      .mask_valid_o   (mask_valid),
      .mask_o         (mask),
      .mask_hcount_o  (mask_hcount),
      .mask_vcount_o  (mask_vcount)
   );

   center_of_mass u_center_of_mass (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .mask_valid_i   (mask_valid),
      .mask_i         (mask),
      .hcount_i       (mask_hcount),
      .vcount_i       (mask_vcount),
      .x_com_o        (x_com_o),
      .y_com_o        (y_com_o),
      .com_valid_o    (com_valid_o)
   );

   beat_detector u_beat_detector (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .com_valid_i    (com_valid_o),
      .y_com_i        (y_com_o),
      .beat_o         (beat_o)
   );

   // reports the held center, not only fresh results
   telemetry_tx u_telemetry_tx (
      .clk_camera     (clk_camera),
      .sys_rst_camera (sys_rst_camera),
      .y_com_i        (y_com_o),
      .beat_i         (beat_o),
      .uart_txd_o     (uart_txd_o)
   );

endmodule

`default_nettype wire

// ==== hdl/telemetry_tx.sv ====
`timescale 1ns/1ns
`default_nettype none

module telemetry_tx import baton_pkg::*; (
   input  logic                clk_camera,
   input  logic                sys_rst_camera,
   input  logic [VCOUNT_W-1:0] y_com_i,
   input  logic                beat_i,
   output logic                uart_txd_o
);

   logic [$clog2(REPORT_PERIOD)-1:0] report_cnt;
   logic                             launch_y;
   logic                             launch_flag;
   // remembers any beat since the last flag byte
   logic                             beat_seen;
   logic [7:0]                       tx_byte;
   tx_state_t                        state;
   logic [$clog2(CLKS_PER_BIT)-1:0]  bit_timer;
   logic                             bit_done;
   logic [2:0]                       bit_idx;

   assign launch_y = (report_cnt == REPORT_Y_AT);
   assign launch_flag = (report_cnt == REPORT_BEAT_AT);
   assign bit_done = (bit_timer == CLKS_PER_BIT - 1);

   // free-running report schedule
   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera || (report_cnt == REPORT_PERIOD - 1)) begin
         report_cnt <= '0;
      end else begin
         report_cnt <= report_cnt + 1'b1;
      end
   end

   // a beat arriving on the latch cycle goes to the next flag byte
   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         beat_seen <= 1'b0;
      end else if (launch_flag) begin
         beat_seen <= beat_i;
      end else begin
         beat_seen <= beat_seen | beat_i;
      end
   end

   always_ff @(posedge clk_camera) begin
      if (launch_y) begin
         tx_byte <= y_com_i;
      end else if (launch_flag) begin
         tx_byte <= {beat_seen, 7'b0};
      end
   end

   // 8n1 serializer, lsb first
   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         state <= TX_IDLE;
         uart_txd_o <= 1'b1;
         bit_timer <= '0;
         bit_idx <= '0;
      end else begin
         bit_timer <= bit_done ? '0 : bit_timer + 1'b1;
         case (state)
            TX_IDLE: begin
               bit_timer <= '0;
               // line is always idle here, a frame is only 80 cycles
               if (launch_y || launch_flag) begin
                  state <= TX_START;
                  uart_txd_o <= 1'b0;
               end
            end
            TX_START: begin
               if (bit_done) begin
                  state <= TX_DATA;
                  uart_txd_o <= tx_byte[0];
                  bit_idx <= '0;
               end
            end
            TX_DATA: begin
               if (bit_done) begin
                  if (bit_idx == 3'd7) begin
                     state <= TX_STOP;
                     uart_txd_o <= 1'b1;
                  end else begin
                     bit_idx <= bit_idx + 1'b1;
                     uart_txd_o <= tx_byte[bit_idx + 3'd1];
                  end
               end
            end
            TX_STOP: begin
               if (bit_done) begin
                  state <= TX_IDLE;
               end
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== hdl/beat_detector.sv ====
`timescale 1ns/1ns
`default_nettype none

module beat_detector import baton_pkg::*; (
   input  logic                clk_camera,
   input  logic                sys_rst_camera,
   input  logic                com_valid_i,
   input  logic [VCOUNT_W-1:0] y_com_i,
   output logic                beat_o
);

   logic [VCOUNT_W-1:0] prev_y;
   // 1 while the baton moves down the picture
   logic                dir_down;

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         prev_y <= '0;
         dir_down <= 1'b0;
         beat_o <= 1'b0;
      end else begin
         beat_o <= 1'b0;
         if (com_valid_i) begin
            prev_y <= y_com_i;
            // vcount grows downward
            if (y_com_i > prev_y) begin
               dir_down <= 1'b1;
            end else if (y_com_i < prev_y) begin
               dir_down <= 1'b0;
               // bottom of the stroke is the beat
               beat_o <= dir_down;
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== hdl/center_of_mass.sv ====
`timescale 1ns/1ns
`default_nettype none

module center_of_mass import baton_pkg::*; (
   input  logic                clk_camera,
   input  logic                sys_rst_camera,
   input  logic                mask_valid_i,
   input  logic                mask_i,
   input  logic [HCOUNT_W-1:0] hcount_i,
   input  logic [VCOUNT_W-1:0] vcount_i,
   output logic [HCOUNT_W-1:0] x_com_o,
   output logic [VCOUNT_W-1:0] y_com_o,
   output logic                com_valid_o
);

   com_state_t           state;
   logic [SUM_X_W-1:0]   sum_x;
   logic [SUM_Y_W-1:0]   sum_y;
   logic [CNT_W-1:0]     count;
   logic                 hit;
   logic                 frame_end;
   // running totals including the current pixel
   logic [SUM_X_W-1:0]   tot_x;
   logic [SUM_Y_W-1:0]   tot_y;
   logic [CNT_W-1:0]     tot_cnt;
   // dividend shifts out at the top while quotient bits shift in below
   logic [DIV_W-1:0]     quo_x;
   logic [DIV_W-1:0]     quo_y;
   logic [DIV_W-1:0]     quo_x_nxt;
   logic [DIV_W-1:0]     quo_y_nxt;
   logic [CNT_W-1:0]     rem_x;
   logic [CNT_W-1:0]     rem_y;
   logic [CNT_W-1:0]     divisor;
   // msb is the quotient bit, the rest the new remainder
   logic [CNT_W:0]       step_x;
   logic [CNT_W:0]       step_y;
   // shared by both dividers
   logic [DIV_CNT_W-1:0] bit_cnt;

   // one restoring division step
   function automatic logic [CNT_W:0] div_step(input logic [CNT_W-1:0] rem,
                                               input logic in_bit,
                                               input logic [CNT_W-1:0] dvs);
      logic [CNT_W:0] shifted;
      logic [CNT_W:0] diff;
      shifted = {rem, in_bit};
      diff = shifted - {1'b0, dvs};
      if (shifted >= {1'b0, dvs}) begin
         div_step = {1'b1, diff[CNT_W-1:0]};
      end else begin
         div_step = {1'b0, shifted[CNT_W-1:0]};
      end
   endfunction

   always_comb begin
      hit = mask_valid_i && mask_i;
      // last pixel of the frame closes the sums
      frame_end = mask_valid_i && (hcount_i == HCOUNT_W'(FRAME_W - 1))
                  && (vcount_i == VCOUNT_W'(FRAME_H - 1));
      tot_x = sum_x + (hit ? SUM_X_W'(hcount_i) : '0);
      tot_y = sum_y + (hit ? SUM_Y_W'(vcount_i) : '0);
      tot_cnt = count + CNT_W'(hit);
      step_x = div_step(rem_x, quo_x[DIV_W-1], divisor);
      step_y = div_step(rem_y, quo_y[DIV_W-1], divisor);
      quo_x_nxt = {quo_x[DIV_W-2:0], step_x[CNT_W]};
      quo_y_nxt = {quo_y[DIV_W-2:0], step_y[CNT_W]};
   end

   // accumulators keep running while the dividers work
   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera || frame_end) begin
         sum_x <= '0;
         sum_y <= '0;
         count <= '0;
      end else begin
         sum_x <= tot_x;
         sum_y <= tot_y;
         count <= tot_cnt;
      end
   end

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         state <= COM_ACCUM;
         com_valid_o <= 1'b0;
         x_com_o <= '0;
         y_com_o <= '0;
      end else begin
         com_valid_o <= 1'b0;
         case (state)
            COM_ACCUM: begin
               // empty frame leaves the old center in place
               if (frame_end && (tot_cnt != '0)) begin
                  state <= COM_DIVIDE;
               end
            end
            COM_DIVIDE: begin
               if (bit_cnt == DIV_CNT_W'(DIV_W - 1)) begin
                  state <= COM_ACCUM;
                  com_valid_o <= 1'b1;
                  x_com_o <= quo_x_nxt[HCOUNT_W-1:0];
                  y_com_o <= quo_y_nxt[VCOUNT_W-1:0];
               end
            end
            default: state <= COM_ACCUM;
         endcase
      end
   end

   // divider datapath, loaded at frame end
   always_ff @(posedge clk_camera) begin
      if (state == COM_ACCUM) begin
         if (frame_end) begin
            quo_x <= DIV_W'(tot_x);
            quo_y <= DIV_W'(tot_y);
            divisor <= tot_cnt;
            rem_x <= '0;
            rem_y <= '0;
            bit_cnt <= '0;
         end
      end else begin
         quo_x <= quo_x_nxt;
         quo_y <= quo_y_nxt;
         rem_x <= step_x[CNT_W-1:0];
         rem_y <= step_y[CNT_W-1:0];
         bit_cnt <= bit_cnt + 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== hdl/cr_threshold.sv ====
`timescale 1ns/1ns
`default_nettype none

module cr_threshold import baton_pkg::*; (
   input  logic                clk_camera,
   input  logic                sys_rst_camera,
   input  logic                pixel_valid_i,
   input  logic [15:0]         pixel_data_i,
   input  logic [HCOUNT_W-1:0] hcount_i,
   input  logic [VCOUNT_W-1:0] vcount_i,
   output logic                mask_valid_o,
   output logic                mask_o,
   output logic [HCOUNT_W-1:0] mask_hcount_o,
   output logic [VCOUNT_W-1:0] mask_vcount_o
);

   // rgb565 fields widened to 8 bits with zero fill
   logic [7:0]          r8;
   logic [7:0]          g8;
   logic [7:0]          b8;
   // stage 1 registers
   logic                valid_s1;
   logic [HCOUNT_W-1:0] hcount_s1;
   logic [VCOUNT_W-1:0] vcount_s1;
   logic [15:0]         prod_r;
   logic [15:0]         prod_g;
   logic [15:0]         prod_b;
   // stage 2 arithmetic, signed so the shift keeps the sign
   logic signed [16:0]  cr_diff;
   logic signed [16:0]  cr_val;

   assign r8 = {pixel_data_i[15:11], 3'b000};
   assign g8 = {pixel_data_i[10:5], 2'b00};
   assign b8 = {pixel_data_i[4:0], 3'b000};

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         valid_s1 <= 1'b0;
         mask_valid_o <= 1'b0;
      end else begin
         valid_s1 <= pixel_valid_i;
         mask_valid_o <= valid_s1;
      end
   end

   // cr = 128 + (112r - 94g - 18b) / 256
   always_comb begin
      cr_diff = $signed({1'b0, prod_r}) - $signed({1'b0, prod_g}) - $signed({1'b0, prod_b});
      cr_val = 17'sd128 + (cr_diff >>> 8);
   end

   always_ff @(posedge clk_camera) begin
      // products first, one pixel per cycle can be in flight
      prod_r <= r8 * 16'd112;
      prod_g <= g8 * 16'd94;
      prod_b <= b8 * 16'd18;
      hcount_s1 <= hcount_i;
      vcount_s1 <= vcount_i;
      // window compare and aligned coordinates
      mask_o <= (cr_val >= CR_LOW) && (cr_val <= CR_HIGH);
      mask_hcount_o <= hcount_s1;
      mask_vcount_o <= vcount_s1;
   end

endmodule

`default_nettype wire

// ==== hdl/pixel_reconstruct.sv ====
`timescale 1ns/1ns
`default_nettype none

module pixel_reconstruct import baton_pkg::*; (
   input  logic                clk_camera,
   input  logic                sys_rst_camera,
   input  logic [7:0]          camera_d_i,
   input  logic                cam_pclk_i,
   input  logic                cam_hsync_i,
   input  logic                cam_vsync_i,
   output logic                pixel_valid_o,
   output logic [15:0]         pixel_data_o,
   output logic [HCOUNT_W-1:0] hcount_o,
   output logic [VCOUNT_W-1:0] vcount_o
);

   // two-flop synchronizers, bit 1 is the safe copy
   logic [7:0]          d_meta;
   logic [7:0]          d_sync;
   logic [1:0]          pclk_sr;
   logic [1:0]          hsync_sr;
   logic [1:0]          vsync_sr;
   // previous synchronized levels for edge detection
   logic                pclk_prev;
   logic                hsync_prev;
   logic                pclk_rise;
   logic                hsync_fall;
   logic                take_byte;
   logic                in_frame;
   // 0 while waiting for the high byte of a pixel
   logic                byte_phase;
   logic [7:0]          hi_byte;
   logic [HCOUNT_W-1:0] hcount;
   logic [VCOUNT_W-1:0] vcount;

   always_ff @(posedge clk_camera) begin
      d_meta <= camera_d_i;
      d_sync <= d_meta;
   end

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         pclk_sr <= '0;
         hsync_sr <= '0;
         vsync_sr <= '0;
         pclk_prev <= 1'b0;
         hsync_prev <= 1'b0;
      end else begin
         pclk_sr <= {pclk_sr[0], cam_pclk_i};
         hsync_sr <= {hsync_sr[0], cam_hsync_i};
         vsync_sr <= {vsync_sr[0], cam_vsync_i};
         pclk_prev <= pclk_sr[1];
         hsync_prev <= hsync_sr[1];
      end
   end

   assign pclk_rise = pclk_sr[1] && !pclk_prev;
   assign hsync_fall = !hsync_sr[1] && hsync_prev;
   // bytes only count while the line is active
   assign take_byte = pclk_rise && hsync_sr[1];
   // drop anything beyond the expected frame size
   assign in_frame = (hcount < FRAME_W) && (vcount < FRAME_H);

   always_ff @(posedge clk_camera) begin
      if (sys_rst_camera) begin
         pixel_valid_o <= 1'b0;
         byte_phase <= 1'b0;
         hcount <= '0;
         vcount <= '0;
      end else begin
         pixel_valid_o <= 1'b0;
         // vsync holds the line counter at the top of the frame
         if (vsync_sr[1]) begin
            vcount <= '0;
         end else if (hsync_fall) begin
            vcount <= vcount + 1'b1;
         end
         if (hsync_fall) begin
            byte_phase <= 1'b0;
            hcount <= '0;
         end else if (take_byte) begin
            byte_phase <= !byte_phase;
            // second byte completes the pixel
            if (byte_phase) begin
               hcount <= hcount + 1'b1;
               pixel_valid_o <= in_frame;
            end
         end
      end
   end

   // pixel payload, qualified by pixel_valid_o
   always_ff @(posedge clk_camera) begin
      if (take_byte) begin
         if (!byte_phase) begin
            hi_byte <= d_sync;
         end else begin
            pixel_data_o <= {hi_byte, d_sync};
            hcount_o <= hcount;
            vcount_o <= vcount;
         end
      end
   end

endmodule

`default_nettype wire

// ==== hdl/baton_pkg.sv ====
package baton_pkg;

   // camera frame geometry, one frame is 320x180 pixels
   localparam int FRAME_W = 320;
   localparam int FRAME_H = 180;
   localparam int HCOUNT_W = 9;
   localparam int VCOUNT_W = 8;

   // inclusive pink window on 8-bit cr
   localparam int CR_LOW = 160;
   localparam int CR_HIGH = 240;

   // per-frame accumulator widths
   localparam int SUM_X_W = 25;
   localparam int SUM_Y_W = 25;
   localparam int CNT_W = 16;

   // divider length covers the wider of the two sums
   localparam int DIV_W = (SUM_X_W > SUM_Y_W) ? SUM_X_W : SUM_Y_W;
   localparam int DIV_CNT_W = $clog2(DIV_W + 1);

   // uart bit time and report schedule, all in clk_camera cycles
   localparam int CLKS_PER_BIT = 8;
   localparam int REPORT_PERIOD = 400;
   localparam int REPORT_Y_AT = 100;
   localparam int REPORT_BEAT_AT = 300;

   typedef enum logic {COM_ACCUM, COM_DIVIDE} com_state_t;
   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_t;

endpackage
